/* verilog/fp_format_pkg.sv */
`default_nettype none

package fp_format_pkg;

    typedef enum logic {
        FP32 = 1'b0,
        FP16 = 1'b1
    } fp_fmt_e;

    function automatic int exp_bits(fp_fmt_e fmt);
        return (fmt == FP16) ? 5 : 8;
    endfunction

    function automatic int man_bits(fp_fmt_e fmt);
        return (fmt == FP16) ? 10 : 23;
    endfunction

    function automatic int fp_bias(fp_fmt_e fmt);
        return (1 << (exp_bits(fmt) - 1)) - 1;
    endfunction

    // Operand class bits as decoded from the exponent and mantissa fields.
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_signalling;
        logic is_subnormal;
    } fp_class_t;

    // Exception flags, in the bit order of the fflags CSR.
    typedef struct packed {
        logic NV;
        logic DZ;
        logic OF;
        logic UF;
        logic NX;
    } fp_flags_t;

endpackage

`default_nettype wire

/* verilog/fp_ctrl_pkg.sv */
`default_nettype none

package fp_ctrl_pkg;

    // Encodings follow the rm field of the RISC-V float instructions.
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } round_mode_e;

    typedef enum logic {
        MUL_POS = 1'b0,
        MUL_NEG = 1'b1 // Used by the negated fused forms.
    } mul_op_e;

endpackage

`default_nettype wire

/* verilog/fp_round_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface fp_round_if
    import fp_format_pkg::*;
    import fp_ctrl_pkg::*;
#(
    parameter fp_fmt_e FP_FMT = FP32
);
    localparam int MAN_W = man_bits(FP_FMT);

    logic [MAN_W-1:0] mant;      // Truncated mantissa before rounding.
    logic             guard;
    logic             sticky;
    logic             sign;
    round_mode_e      mode;
    logic [MAN_W-1:0] mant_out;
    logic             inexact;
    logic             carry_out; // Set when the increment wraps the mantissa.

    modport mul (
        output mant, guard, sticky, sign, mode,
        input  mant_out, inexact, carry_out
    );

    modport rnd (
        input  mant, guard, sticky, sign, mode,
        output mant_out, inexact, carry_out
    );

endinterface

`default_nettype wire

/* verilog/fp_classify.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_classify
    import fp_format_pkg::*;
#(
    parameter fp_fmt_e FP_FMT = FP32,
    parameter int      XLEN   = 32
) (
    input  logic [XLEN-1:0] operand_i,
    output fp_class_t       class_o
);
    localparam int EXP_W = exp_bits(FP_FMT);
    localparam int MAN_W = man_bits(FP_FMT);

    logic [EXP_W-1:0] exp_f;
    logic [MAN_W-1:0] man_f;
    logic             exp_ones;
    logic             exp_zero;
    logic             man_zero;

    assign exp_f = operand_i[MAN_W +: EXP_W];
    assign man_f = operand_i[MAN_W-1:0];

    assign exp_ones = &exp_f;
    assign exp_zero = ~|exp_f;
    assign man_zero = ~|man_f;

    assign class_o.is_zero      = exp_zero & man_zero;
    assign class_o.is_subnormal = exp_zero & ~man_zero;
    assign class_o.is_inf       = exp_ones & man_zero;
    assign class_o.is_nan       = exp_ones & ~man_zero;
    // A clear quiet bit marks a signalling NaN.
    assign class_o.is_signalling = exp_ones & ~man_zero & ~man_f[MAN_W-1];

endmodule

`default_nettype wire

/* verilog/lead_zero_count.sv */
`timescale 1ns/10ps
`default_nettype none

module lead_zero_count #(
    parameter  int WIDTH = 24,
    localparam int CNT_W = $clog2(WIDTH)
) (
    input  logic [WIDTH-1:0] value_i,
    output logic [CNT_W-1:0] count_o
);

    // Scan from the LSB so that the highest set bit wins.
    always_comb begin
        count_o = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (value_i[i]) begin
                count_o = CNT_W'(WIDTH - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/booth_mant_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module booth_mant_mul #(
    parameter int WIDTH = 24
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [WIDTH-1:0]   a_i,
    input  logic [WIDTH-1:0]   b_i,
    output logic [2*WIDTH-1:0] product_o
);
    localparam int NPP = WIDTH / 2 + 1; // One extra digit keeps the multiplier unsigned.
    localparam int PW  = 2 * WIDTH;

    logic [2*NPP:0] b_ext;
    logic [PW-1:0]  a_ext;
    logic [PW-1:0]  pp [NPP];
    logic [PW-1:0]  sum_d;
    logic [PW-1:0]  carry_d;
    logic [PW-1:0]  sum_q;
    logic [PW-1:0]  carry_q;

    assign b_ext = {{(2*NPP-WIDTH){1'b0}}, b_i, 1'b0};
    assign a_ext = PW'(a_i);

    // Radix-4 digits, each from an overlapping triplet of multiplier bits.
    always_comb begin
        logic [PW-1:0] row;
        for (int i = 0; i < NPP; i++) begin
            case (b_ext[2*i +: 3])
                3'b001, 3'b010: row = a_ext;
                3'b011:         row = a_ext << 1;
                3'b100:         row = -(a_ext << 1);
                3'b101, 3'b110: row = -a_ext;
                default:        row = '0;
            endcase
            pp[i] = row << (2 * i);
        end
    end

    // Carry-save reduction. All sums wrap at PW bits, which holds the full product.
    always_comb begin
        logic [PW-1:0] s;
        logic [PW-1:0] c;
        logic [PW-1:0] t;
        s = pp[0];
        c = pp[1];
        for (int i = 2; i < NPP; i++) begin
            t = s ^ c ^ pp[i];
            c = ((s & c) | (s & pp[i]) | (c & pp[i])) << 1;
            s = t;
        end
        sum_d   = s;
        carry_d = c;
    end

    always_ff @(posedge clk) begin
        sum_q     <= sum_d;
        carry_q   <= carry_d;
        product_o <= sum_q + carry_q;
    end

    // Two normalized significands give a product in the top two bit positions.
    a_prod_msb: assert property (@(posedge clk) disable iff (!arst_n_i)
        $past(a_i[WIDTH-1] & b_i[WIDTH-1], 2) |-> (product_o[PW-1 -: 2] != 2'b00))
        else $error("booth_mant_mul product lost its leading bits");

endmodule

`default_nettype wire

/* verilog/fp_round.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_round
    import fp_format_pkg::*;
    import fp_ctrl_pkg::*;
#(
    parameter fp_fmt_e FP_FMT = FP32
) (
    fp_round_if.rnd rif
);
    localparam int MAN_W = man_bits(FP_FMT);

    logic             inexact;
    logic             round_up;
    logic [MAN_W:0]   sum;

    assign inexact = rif.guard | rif.sticky;

    always_comb begin
        case (rif.mode)
            RNE:     round_up = rif.guard & (rif.sticky | rif.mant[0]); // Ties go to even.
            RTZ:     round_up = 1'b0;
            RDN:     round_up = inexact & rif.sign;
            RUP:     round_up = inexact & ~rif.sign;
            RMM:     round_up = rif.guard;
            default: round_up = 1'b0;
        endcase
    end

    assign sum = {1'b0, rif.mant} + (MAN_W+1)'(round_up);

    assign rif.mant_out  = sum[MAN_W-1:0];
    assign rif.carry_out = sum[MAN_W];
    assign rif.inexact   = inexact;

endmodule

`default_nettype wire

/* verilog/fp_mul.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul
    import fp_format_pkg::*;
    import fp_ctrl_pkg::*;
#(
    parameter fp_fmt_e FP_FMT = FP32,
    parameter int      XLEN   = 32
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  mul_op_e         op_i,
    input  round_mode_e     rm_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic            valid_o,
    output logic [XLEN-1:0] result_o,
    output fp_flags_t       flags_o
);
    localparam int EXP_W   = exp_bits(FP_FMT);
    localparam int MAN_W   = man_bits(FP_FMT);
    localparam int BIAS    = fp_bias(FP_FMT);
    localparam int FW      = 1 + EXP_W + MAN_W;
    localparam int SIG_W   = MAN_W + 1;
    localparam int PROD_W  = 2 * SIG_W;
    localparam int LZ_W    = $clog2(SIG_W);
    localparam int EW      = EXP_W + 2; // Signed exponent with room for both extremes.
    localparam int SH_W    = $clog2(PROD_W + 1);
    localparam int MAX_EXP = (1 << EXP_W) - 1;

    fp_class_t            cls_a, cls_b;
    logic                 sign_a, sign_b, sign_p;
    logic [EXP_W-1:0]     exp_a, exp_b, exp_eff_a, exp_eff_b;
    logic [MAN_W-1:0]     man_a, man_b;
    logic [SIG_W-1:0]     sig_a, sig_b, lz_src, norm_a, norm_b;
    logic [LZ_W-1:0]      lz_cnt;
    logic signed [EW-1:0] exp_sum, shr_full, exp_s1, exp_s2, exp_pre, exp_rnd;
    logic [SH_W-1:0]      shr_d, shr_s2;
    logic [FW-1:0]        spec_res, spec_res_s1, spec_res_s2, norm_res;
    fp_flags_t            spec_flags, spec_flags_s1, spec_flags_s2, norm_flags;
    logic                 spec_sel, spec_sel_s1, spec_sel_s2;
    logic                 valid_s1, sign_s1, sign_s2;
    round_mode_e          rm_s1, rm_s2;
    logic [PROD_W-1:0]    prod, prod_sh, prod_nm;
    logic                 sticky_sh, ovf, ovf_inf;

    assign {sign_a, exp_a, man_a} = a_i[FW-1:0];
    assign {sign_b, exp_b, man_b} = b_i[FW-1:0];
    assign sign_p = sign_a ^ sign_b ^ (op_i == MUL_NEG);

    fp_classify #(.FP_FMT(FP_FMT), .XLEN(XLEN)) classify_a_i (.operand_i(a_i), .class_o(cls_a));
    fp_classify #(.FP_FMT(FP_FMT), .XLEN(XLEN)) classify_b_i (.operand_i(b_i), .class_o(cls_b));

    // A subnormal has the exponent of the smallest normal and no hidden bit.
    assign exp_eff_a = (|exp_a) ? exp_a : EXP_W'(1);
    assign exp_eff_b = (|exp_b) ? exp_b : EXP_W'(1);
    assign sig_a     = {|exp_a, man_a};
    assign sig_b     = {|exp_b, man_b};
    assign lz_src    = cls_a.is_subnormal ? sig_a : sig_b;

    lead_zero_count #(.WIDTH(SIG_W)) lzc_i (.value_i(lz_src), .count_o(lz_cnt));

    assign norm_a  = cls_a.is_subnormal ? sig_a << lz_cnt : sig_a;
    assign norm_b  = cls_b.is_subnormal ? sig_b << lz_cnt : sig_b;
    assign exp_sum = EW'(exp_eff_a) + EW'(exp_eff_b) - EW'(BIAS) - EW'(lz_cnt);

    booth_mant_mul #(.WIDTH(SIG_W)) booth_i (
        .clk(clk), .arst_n_i(arst_n_i), .a_i(norm_a), .b_i(norm_b), .product_o(prod)
    );

    always_comb begin
        spec_sel   = 1'b1;
        spec_res   = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MAN_W-1){1'b0}}}; // Canonical NaN.
        spec_flags = '0;
        if ((cls_a.is_inf & cls_b.is_zero) | (cls_a.is_zero & cls_b.is_inf)) begin
            spec_flags.NV = 1'b1;
        end else if (cls_a.is_nan | cls_b.is_nan) begin
            spec_flags.NV = cls_a.is_signalling | cls_b.is_signalling;
        end else if (cls_a.is_inf | cls_b.is_inf) begin
            spec_res = {sign_p, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
        end else if (cls_a.is_zero | cls_b.is_zero) begin
            spec_res = {sign_p, {(FW-1){1'b0}}};
        end else if (cls_a.is_subnormal & cls_b.is_subnormal) begin
            spec_res      = {sign_p, {(FW-1){1'b0}}};
            spec_flags.UF = 1'b1;
            spec_flags.NX = 1'b1;
        end else begin
            spec_sel = 1'b0;
        end
    end

    // Right shift that brings a tiny result into the subnormal range.
    assign shr_full = EW'(1) - exp_s1;
    assign shr_d = (exp_s1 > 0) ? '0 : (shr_full > PROD_W) ? SH_W'(PROD_W) : SH_W'(shr_full);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_s1 <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_s1 <= valid_i;
            valid_o  <= valid_s1;
        end
    end

    always_ff @(posedge clk) begin
        exp_s1        <= exp_sum;
        sign_s1       <= sign_p;
        rm_s1         <= rm_i;
        spec_sel_s1   <= spec_sel;
        spec_res_s1   <= spec_res;
        spec_flags_s1 <= spec_flags;
        shr_s2        <= shr_d;
        exp_s2        <= exp_s1;
        sign_s2       <= sign_s1;
        rm_s2         <= rm_s1;
        spec_sel_s2   <= spec_sel_s1;
        spec_res_s2   <= spec_res_s1;
        spec_flags_s2 <= spec_flags_s1;
    end

    assign prod_sh   = prod >> shr_s2;
    assign sticky_sh = |(prod & ~({PROD_W{1'b1}} << shr_s2));
    assign prod_nm   = prod_sh[PROD_W-1] ? prod_sh : prod_sh << 1;
    // After a subnormal shift the hidden bit alone decides between exponent 0 and 1.
    assign exp_pre = (|shr_s2) ? EW'(prod_sh[PROD_W-2]) : exp_s2 + EW'(prod[PROD_W-1]);

    fp_round_if #(.FP_FMT(FP_FMT)) rnd_if ();

    assign rnd_if.mant   = prod_nm[PROD_W-2 -: MAN_W];
    assign rnd_if.guard  = prod_nm[PROD_W-2-MAN_W];
    assign rnd_if.sticky = (|prod_nm[PROD_W-3-MAN_W:0]) | sticky_sh;
    assign rnd_if.sign   = sign_s2;
    assign rnd_if.mode   = rm_s2;

    fp_round #(.FP_FMT(FP_FMT)) round_i (.rif(rnd_if.rnd));

    assign exp_rnd = exp_pre + EW'(rnd_if.carry_out);
    assign ovf     = exp_rnd >= MAX_EXP;
    assign ovf_inf = (rm_s2 == RNE) | (rm_s2 == RMM) | ((rm_s2 == RUP) & ~sign_s2)
                   | ((rm_s2 == RDN) & sign_s2);

    always_comb begin
        if (!ovf) begin
            norm_res = {sign_s2, exp_rnd[EXP_W-1:0], rnd_if.mant_out};
        end else if (ovf_inf) begin
            norm_res = {sign_s2, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
        end else begin
            norm_res = {sign_s2, {(EXP_W-1){1'b1}}, 1'b0, {MAN_W{1'b1}}}; // Largest finite.
        end
    end

    assign norm_flags = '{NV: 1'b0, DZ: 1'b0, OF: ovf,
                          UF: rnd_if.inexact & ~ovf & (exp_pre == 0),
                          NX: rnd_if.inexact | ovf};

    assign result_o = XLEN'(spec_sel_s2 ? spec_res_s2 : norm_res);
    assign flags_o  = spec_sel_s2 ? spec_flags_s2 : norm_flags;

    // An all-ones exponent only leaves for infinity, NaN or an overflow.
    a_exp_ones: assert property (@(posedge clk) disable iff (!arst_n_i)
        valid_o && (result_o[FW-2 -: EXP_W] == {EXP_W{1'b1}}) |-> spec_sel_s2 || flags_o.OF)
        else $error("fp_mul all-ones exponent on a finite result");

endmodule

`default_nettype wire

/* verilog/fp_mul_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_top
    import fp_format_pkg::*;
    import fp_ctrl_pkg::*;
#(
    parameter fp_fmt_e FP_FMT = FP32,
    parameter int      XLEN   = 32
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            valid_i,
    input  mul_op_e         op_i,
    input  round_mode_e     rm_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic            valid_o,
    output logic [XLEN-1:0] result_o,
    output fp_flags_t       flags_o
);

    fp_mul #(
        .FP_FMT (FP_FMT),
        .XLEN   (XLEN)
    ) fp_mul_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .rm_i     (rm_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

endmodule

`default_nettype wire

/* testbench/fp_mul_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_tb
    import fp_format_pkg::*;
    import fp_ctrl_pkg::*;
();
    localparam int MAX_VEC = 64;
    localparam int RST_CYCLES = 4;
    localparam int LATENCY = 2;

    logic            clk;
    logic            arst_n_i;
    logic            valid_i;
    mul_op_e         op_i;
    round_mode_e     rm_i;
    logic [31:0]     a_i;
    logic [31:0]     b_i;
    logic            valid_o;
    logic [31:0]     result_o;
    fp_flags_t       flags_o;

    logic [8*16-1:0] name_vec [MAX_VEC];
    logic            op_vec   [MAX_VEC];
    logic [2:0]      rm_vec   [MAX_VEC];
    logic [31:0]     a_vec    [MAX_VEC];
    logic [31:0]     b_vec    [MAX_VEC];
    logic [31:0]     res_vec  [MAX_VEC];
    logic [4:0]      flg_vec  [MAX_VEC];
    int              num_vec = 0;
    int              exp_q[$];      // Indices of vectors still in the pipeline.
    int              cycles = 0;
    int              limit = 0;

    fp_mul_top #(
        .FP_FMT (FP32),
        .XLEN   (32)
    ) fp_mul_top_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .rm_i     (rm_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [8*16-1:0] name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s %0s expected %h actual %h", name, what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "check failed on %0s", name);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // Outputs change on the rising edge, so they are sampled on the falling one.
    always @(negedge clk) begin
        int idx;
        if (valid_o) begin
            if (exp_q.size() == 0) begin
                $display("valid_o was raised with no operation outstanding");
                $display("STATUS: FAIL");
                $fatal(1, "unexpected valid_o");
            end else begin
                idx = exp_q.pop_front();
                check_value(name_vec[idx], "result", res_vec[idx], result_o);
                check_value(name_vec[idx], "flags", 32'(flg_vec[idx]), 32'(flags_o));
            end
        end
    end

    initial begin
        int              fd;
        int              cnt;
        int              waited;
        logic [8*128-1:0] line;
        logic [8*16-1:0] t_name;
        logic [31:0]     t_op, t_rm, t_a, t_b, t_res, t_flg;

        arst_n_i = 1'b0;
        valid_i  = 1'b0;
        op_i     = MUL_POS;
        rm_i     = RNE;
        a_i      = '0;
        b_i      = '0;

        fd = $fopen("testbench/fp_mul_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/fp_mul_input.txt");
            $display("STATUS: FAIL");
            $fatal(1, "no input file");
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%s %h %h %h %h %h %h",
                              t_name, t_op, t_rm, t_a, t_b, t_res, t_flg);
                // Comment and blank lines do not yield all seven fields.
                if (cnt == 7 && num_vec < MAX_VEC) begin
                    name_vec[num_vec] = t_name;
                    op_vec[num_vec]   = t_op[0];
                    rm_vec[num_vec]   = t_rm[2:0];
                    a_vec[num_vec]    = t_a;
                    b_vec[num_vec]    = t_b;
                    res_vec[num_vec]  = t_res;
                    flg_vec[num_vec]  = t_flg[4:0];
                    num_vec++;
                end
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            $display("The input file holds no test vectors");
            $display("STATUS: FAIL");
            $fatal(1, "empty input file");
        end
        limit = num_vec + RST_CYCLES + LATENCY + 20;

        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n_i = 1'b1;

        // One vector per cycle, so the pipeline runs back to back.
        for (int i = 0; i < num_vec; i++) begin
            @(posedge clk);
            #1;
            valid_i = 1'b1;
            op_i    = mul_op_e'(op_vec[i]);
            rm_i    = round_mode_e'(rm_vec[i]);
            a_i     = a_vec[i];
            b_i     = b_vec[i];
            exp_q.push_back(i);
        end
        @(posedge clk);
        #1 valid_i = 1'b0;

        waited = 0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        repeat (2) @(negedge clk); // Any late extra valid_o is caught here.

        if (exp_q.size() != 0) begin
            $display("%0d operations produced no valid_o", exp_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "missing results");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/fp_mul_input.txt */
# Columns: test name, op (0 mul, 1 negated), rounding mode, operand a, operand b,
# then the expected result and flags (NV=10 DZ=08 OF=04 UF=02 NX=01), all in hex.
mul_exact      0 0 40000000 40400000 40C00000 00
neg_exact      1 0 3FC00000 40000000 C0400000 00
tie_rne_up     0 0 3F800001 3FC00000 3FC00002 01
tie_rtz        0 1 3F800001 3FC00000 3FC00001 01
tie_rdn        0 2 3F800001 3FC00000 3FC00001 01
tie_rup        0 3 3F800001 3FC00000 3FC00002 01
tie_rmm        0 4 3F800001 3FC00000 3FC00002 01
tie_rne_even   0 0 3F800003 3FC00000 3FC00004 01
tie_rmm_odd    0 4 3F800003 3FC00000 3FC00005 01
neg_tie_rdn    1 2 3F800001 3FC00000 BFC00002 01
neg_tie_rup    1 3 3F800001 3FC00000 BFC00001 01
sign_tie_rne   0 0 BF800001 3FC00000 BFC00002 01
sticky_rne     0 0 3F800001 3F800001 3F800002 01
sticky_rup     0 3 3F800001 3F800001 3F800003 01
inf_zero       0 0 7F800000 00000000 7FC00000 10
neg_inf_zero   1 0 00000000 7F800000 7FC00000 10
qnan           0 0 7FC00001 3F800000 7FC00000 00
neg_qnan       1 0 3F800000 7FC00000 7FC00000 00
snan           0 0 7F800001 3F800000 7FC00000 10
inf_fin        0 0 7F800000 C0000000 FF800000 00
neg_inf_fin    1 0 7F800000 40000000 FF800000 00
zero_fin       0 0 80000000 40400000 80000000 00
neg_zero       1 0 80000000 40400000 00000000 00
ovf_rne        0 0 7F000000 40000000 7F800000 05
ovf_rtz        0 1 7F000000 40000000 7F7FFFFF 05
ovf_neg_rup    0 3 FF000000 40000000 FF7FFFFF 05
unf_rne        0 0 00800001 3F000000 00400000 03
unf_rup        0 3 00800001 3F000000 00400001 03
sub_sub        0 0 00000001 00000001 00000000 03
sub_sub_neg    0 0 80000001 00000001 80000000 03
sub_norm_min   0 0 00000001 4B000000 00800000 00
sub_norm       0 0 00400000 40400000 00C00000 00
sub_norm_big   0 0 00000003 4F000000 05400000 00
sub_exact_half 0 0 00800000 3F000000 00400000 00

/* all.f */
verilog/fp_format_pkg.sv
verilog/fp_ctrl_pkg.sv
verilog/fp_round_if.sv
verilog/fp_classify.sv
verilog/lead_zero_count.sv
verilog/booth_mant_mul.sv
verilog/fp_round.sv
verilog/fp_mul.sv
verilog/fp_mul_top.sv
testbench/fp_mul_tb.sv

/* Makefile */
TOP = fp_mul_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
